// File: project.f
snes_mem_pkg.sv
sdram_request.sv
read_steer.sv
sdram_store.sv
snes_mem_top.sv
snes_mem_chk.sv
tb_snes_mem.sv

// File: Makefile
TOOL  = verilator
FLAGS = --binary --timing --assert --timescale 1ns/1ps
TOP   = tb_snes_mem
FLIST = project.f
OBJ   = obj_dir
BIN   = $(OBJ)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ) -f $(FLIST)

# pass only when the simulation printed the pass line
run: compile
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "STATUS: PASS"

clean:
	rm -rf $(OBJ)

// File: tb_snes_mem.sv
//////////////////////////////////////////////////////////////////////
// testbench for the snes memory glue, directed tests of loader,
// rom, wram, bsram, aram and run enable
//////////////////////////////////////////////////////////////////////
`default_nettype none

module tb_snes_mem import snes_mem_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_ROM    = 64;       // bytes streamed by the loader
    localparam int N_WRAM   = 64;
    localparam int WRAM_OFS = 'h800;
    localparam int ACC      = 5;        // cycles per core access
    // summed cycle budget of reset and all tests
    localparam int BUDGET = 18 + (2 * N_ROM + 3) + (N_ROM / 2) * ACC + 16 * ACC
                          + (2 * N_WRAM + 1) * ACC + 4 * ACC + 8 + (2 * ACC + 4);
    localparam int WATCHDOG_NS = BUDGET * 8 + 1000;

    logic wclk = 1'b0;
    logic resetn;
    addr_t rom_addr;
    logic rom_ce_n, rom_word;
    logic [WRAM_AW-1:0] wram_addr;
    logic wram_ce_n, wram_rd_n, wram_we_n;
    byte_t wram_d;
    logic [BSRAM_AW-1:0] bsram_addr;
    logic bsram_ce_n, bsram_rd_n, bsram_we_n;
    byte_t bsram_d;
    logic [ARAM_AW-1:0] aram_addr;
    logic aram_ce_n, aram_oe_n, aram_we_n;
    byte_t aram_d;
    logic sysclkf_ce, sysclkr_ce;
    byte_t map_ctrl, loader_data;
    logic loading, loader_valid, loader_fail, pause;
    word_t rom_q;
    byte_t wram_q, bsram_q, aram_q;
    logic enable, core_resetn;

    byte_t  rom_bytes  [N_ROM];     // what the loader wrote
    byte_t  wram_bytes [N_WRAM];
    integer seed;

    snes_mem_top i_snes_mem_top (.*);

    always #4 wclk = ~wclk;         // 8 ns period

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "run stopped at first failure");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp)
            report_failure($sformatf("Mismatch %s: got 0x%h, expected 0x%h",
                                     name, got, exp));
    endtask

    task automatic check_byte(input string name, input byte_t got, input byte_t exp);
        if (got !== exp)
            report_failure($sformatf("Mismatch %s: got 0x%h, expected 0x%h",
                                     name, got, exp));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
            report_failure($sformatf("Mismatch %s: got 0x%h, expected 0x%h",
                                     name, got, exp));
    endtask

    // odd byte sits in the high lane, byte reads of odd addresses swap
    function automatic word_t expected_rom_word(input int a, input logic wmode);
        int    e;
        word_t w;
        e = a & ~1;
        w = {rom_bytes[e + 1], rom_bytes[e]};
        return (wmode || (a % 2 == 0)) ? w : {w[7:0], w[15:8]};
    endfunction

    // one core strobe at the current falling edge, then four rising edges
    task automatic core_cycle(input logic rise);
        sysclkr_ce = rise;
        sysclkf_ce = ~rise;
        @(negedge wclk);
        sysclkr_ce = 1'b0;
        sysclkf_ce = 1'b0;
        repeat (3) @(negedge wclk);
    endtask

    task automatic rom_access(input int a, input logic wmode);
        @(negedge wclk);
        rom_addr = addr_t'(a);
        rom_word = wmode;
        rom_ce_n = 1'b0;
        core_cycle(1'b0);
        rom_ce_n = 1'b1;            // else rom would win over wram
    endtask

    task automatic wram_access(input int i, input logic write);
        @(negedge wclk);
        wram_addr = WRAM_AW'(WRAM_OFS + i);
        wram_d    = wram_bytes[i];
        wram_ce_n = 1'b0;
        wram_we_n = ~write;
        wram_rd_n = write;
        core_cycle(write);          // writes on rise strobe, reads on fall
        if (!write)
            check_byte("wram_q", wram_q, wram_bytes[i]);
        wram_ce_n = 1'b1;
        wram_we_n = 1'b1;
        wram_rd_n = 1'b1;
    endtask

    task automatic bsram_access(input logic [BSRAM_AW-1:0] a, input logic write,
                                input logic rd_level, input byte_t d);
        @(negedge wclk);
        bsram_addr = a;
        bsram_d    = d;
        bsram_ce_n = 1'b0;
        bsram_we_n = ~write;
        bsram_rd_n = write ? 1'b1 : rd_level;
        core_cycle(write);
        bsram_ce_n = 1'b1;
        bsram_we_n = 1'b1;
        bsram_rd_n = 1'b1;
    endtask

    // aram is not strobe gated, one edge per access
    task automatic aram_access(input logic [ARAM_AW-1:0] a, input logic write,
                               input byte_t d);
        @(negedge wclk);
        aram_addr = a;
        aram_d    = d;
        aram_ce_n = 1'b0;
        aram_we_n = ~write;
        aram_oe_n = write;
        @(negedge wclk);
        aram_ce_n = 1'b1;
        aram_we_n = 1'b1;
        aram_oe_n = 1'b1;
    endtask

    task automatic test_loader_fill();
        @(negedge wclk);
        loading = 1'b1;
        @(negedge wclk);            // loader address clears on this edge
        for (int i = 0; i < N_ROM; i++) begin
            check_bit("core_resetn", core_resetn, 1'b0);
            rom_bytes[i] = byte_t'($random(seed));
            loader_data  = rom_bytes[i];
            loader_valid = 1'b1;
            @(negedge wclk);
            loader_valid = 1'b0;
            @(negedge wclk);
        end
        loading = 1'b0;
        @(negedge wclk);
        check_bit("core_resetn", core_resetn, 1'b1);
        for (int a = 0; a < N_ROM; a += 2) begin
            rom_access(a, 1'b1);
            check_word("rom_q", rom_q, expected_rom_word(a, 1'b1));
        end
    endtask

    task automatic test_rom_bytes();
        for (int a = 16; a < 32; a++) begin
            rom_access(a, 1'b0);
            check_word("rom_q", rom_q, expected_rom_word(a, 1'b0));
            check_byte("rom_q[7:0]", rom_q[7:0], rom_bytes[a]);
        end
    endtask

    task automatic test_wram();
        for (int i = 0; i < N_WRAM; i++) begin
            wram_bytes[i] = byte_t'($random(seed));
            wram_access(i, 1'b1);
        end
        for (int i = 0; i < N_WRAM; i++)
            wram_access(i, 1'b0);
        rom_access(2, 1'b1);        // rom data untouched by wram writes
        check_word("rom_q", rom_q, expected_rom_word(2, 1'b1));
    endtask

    task automatic test_bsram();
        byte_t da;
        byte_t db;
        da = byte_t'($random(seed));
        db = ~da;                   // differs, so the forced read shows
        bsram_access(20'h00123, 1'b1, 1'b1, da);
        bsram_access(20'h00456, 1'b1, 1'b1, db);
        bsram_access(20'h00123, 1'b0, 1'b0, 8'h00);
        check_byte("bsram_q", bsram_q, da);
        map_ctrl = {MAP_BSRAM_FORCE_RD, 4'h0};
        bsram_access(20'h00456, 1'b0, 1'b1, 8'h00);     // rd_n stays high
        check_byte("bsram_q", bsram_q, db);
        map_ctrl = 8'h00;
    endtask

    task automatic test_aram();
        byte_t de;
        byte_t dodd;
        de   = byte_t'($random(seed));
        dodd = byte_t'($random(seed));
        aram_access(16'h0100, 1'b1, de);
        aram_access(16'h0101, 1'b1, dodd);
        aram_access(16'h0100, 1'b0, 8'h00);
        check_byte("aram_q", aram_q, de);
        aram_access(16'h0101, 1'b0, 8'h00);
        check_byte("aram_q", aram_q, dodd);
    endtask

    task automatic test_enable();
        word_t held;
        rom_access(6, 1'b1);
        held = expected_rom_word(6, 1'b1);
        check_word("rom_q", rom_q, held);
        check_bit("enable", enable, 1'b1);
        pause = 1'b1;
        @(negedge wclk);
        check_bit("enable", enable, 1'b0);
        rom_access(40, 1'b1);       // gated, rom_q must hold
        check_word("rom_q", rom_q, held);
        pause = 1'b0;
        @(negedge wclk);
        check_bit("enable", enable, 1'b1);
        loader_fail = 1'b1;
        @(negedge wclk);
        check_bit("enable", enable, 1'b0);
        loader_fail = 1'b0;
        @(negedge wclk);
        check_bit("enable", enable, 1'b1);
    endtask

    initial begin
        #(WATCHDOG_NS);
        report_failure("watchdog expired before the tests finished");
    end

    initial begin
        seed = 32'hc20a;
        resetn = 1'b0;
        rom_addr = '0;
        rom_ce_n = 1'b1;
        rom_word = 1'b0;
        wram_addr = '0;
        wram_ce_n = 1'b1;
        wram_rd_n = 1'b1;
        wram_we_n = 1'b1;
        wram_d = '0;
        bsram_addr = '0;
        bsram_ce_n = 1'b1;
        bsram_rd_n = 1'b1;
        bsram_we_n = 1'b1;
        bsram_d = '0;
        aram_addr = '0;
        aram_ce_n = 1'b1;
        aram_oe_n = 1'b1;
        aram_we_n = 1'b1;
        aram_d = '0;
        sysclkf_ce = 1'b0;
        sysclkr_ce = 1'b0;
        map_ctrl = '0;
        loader_data = '0;
        loading = 1'b0;
        loader_valid = 1'b0;
        loader_fail = 1'b0;
        pause = 1'b0;
        repeat (16) @(negedge wclk);
        check_bit("enable", enable, 1'b0);
        resetn = 1'b1;
        @(negedge wclk);
        check_bit("enable", enable, 1'b1);
        test_loader_fill();
        test_rom_bytes();
        test_wram();
        test_bsram();
        test_aram();
        test_enable();
        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: snes_mem_chk.sv
//////////////////////////////////////////////////////////////////////
// request checker bound into sdram_request, watches the
// request strobes and the run enable
//////////////////////////////////////////////////////////////////////
`default_nettype none

module snes_mem_chk (
    input logic wclk,
    input logic resetn,
    input logic enable,
    input logic cpu_rd,
    input logic cpu_wr,
    input logic bsram_req_rd,
    input logic bsram_req_wr
);
    timeunit 1ns;
    timeprecision 100ps;

    // one cpu port access per cycle
    a_cpu_one_op: assert property (@(posedge wclk) disable iff (!resetn)
                                   !(cpu_rd && cpu_wr))
        else $error("cpu_rd and cpu_wr pulsed together");

    a_bsram_one_op: assert property (@(posedge wclk) disable iff (!resetn)
                                     !(bsram_req_rd && bsram_req_wr))
        else $error("bsram read and write requests pulsed together");

    // enable is registered, so it follows reset one edge later
    a_enable_reset: assert property (@(posedge wclk) !resetn |=> !enable)
        else $error("enable high while reset is held");

endmodule

bind sdram_request snes_mem_chk i_snes_mem_chk (
    .wclk, .resetn, .enable, .cpu_rd, .cpu_wr, .bsram_req_rd, .bsram_req_wr
);

`default_nettype wire

// File: snes_mem_top.sv
//////////////////////////////////////////////////////////////////////
// snes memory side top, joins request builder, store and
// read steering into one shared memory path
//////////////////////////////////////////////////////////////////////
`default_nettype none

module snes_mem_top import snes_mem_pkg::*; (
    input  logic                wclk,
    input  logic                resetn,
    input  addr_t               rom_addr,
    input  logic                rom_ce_n,
    input  logic                rom_word,
    input  logic [WRAM_AW-1:0]  wram_addr,
    input  logic                wram_ce_n,
    input  logic                wram_rd_n,
    input  logic                wram_we_n,
    input  byte_t               wram_d,
    input  logic [BSRAM_AW-1:0] bsram_addr,
    input  logic                bsram_ce_n,
    input  logic                bsram_rd_n,
    input  logic                bsram_we_n,
    input  byte_t               bsram_d,
    input  logic [ARAM_AW-1:0]  aram_addr,
    input  logic                aram_ce_n,
    input  logic                aram_oe_n,
    input  logic                aram_we_n,
    input  byte_t               aram_d,
    input  logic                sysclkf_ce,
    input  logic                sysclkr_ce,
    input  byte_t               map_ctrl,
    input  logic                loading,
    input  byte_t               loader_data,
    input  logic                loader_valid,
    input  logic                loader_fail,
    input  logic                pause,
    output word_t               rom_q,
    output byte_t               wram_q,
    output byte_t               bsram_q,
    output byte_t               aram_q,
    output logic                enable,
    output logic                core_resetn   // core held while loading
);

    addr_t               cpu_addr;
    word_t               cpu_din;
    byte_en_t            cpu_ds;
    mem_port_e           cpu_port;
    logic                cpu_rd, cpu_wr;
    logic [BSRAM_AW-1:0] bsram_req_addr;
    byte_t               bsram_req_din;
    logic                bsram_req_rd, bsram_req_wr;
    logic                aram_rd, aram_wr;
    word_t               port0_q, port1_q;
    word_t               aram_dout;

    assign core_resetn = resetn & ~loading;

    sdram_request i_sdram_request (
        .wclk, .resetn, .sysclkf_ce, .sysclkr_ce, .pause, .loader_fail,
        .loading, .loader_valid, .loader_data, .map_ctrl,
        .rom_addr, .rom_ce_n,
        .wram_addr, .wram_ce_n, .wram_rd_n, .wram_we_n, .wram_d,
        .bsram_addr, .bsram_ce_n, .bsram_rd_n, .bsram_we_n, .bsram_d,
        .aram_ce_n, .aram_oe_n, .aram_we_n,
        .enable,
        .cpu_addr, .cpu_din, .cpu_ds, .cpu_port, .cpu_rd, .cpu_wr,
        .bsram_req_addr, .bsram_req_din, .bsram_req_rd, .bsram_req_wr,
        .aram_rd, .aram_wr
    );

    sdram_store i_sdram_store (
        .wclk, .resetn,
        .cpu_addr, .cpu_din, .cpu_ds, .cpu_port, .cpu_rd, .cpu_wr,
        .bsram_req_addr, .bsram_req_din, .bsram_req_rd, .bsram_req_wr,
        .aram_addr, .aram_d, .aram_rd, .aram_wr,
        .port0_q, .port1_q,
        .bsram_dout (bsram_q),      // bsram needs no steering
        .aram_dout
    );

    read_steer i_read_steer (
        .wclk,
        .rom_addr, .rom_word, .port0_q,
        .wram_addr, .port1_q,
        .aram_addr, .aram_rd, .aram_dout,
        .rom_q, .wram_q, .aram_q
    );

endmodule

`default_nettype wire

// File: sdram_store.sv
//////////////////////////////////////////////////////////////////////
// on-chip stand-in for the shared sdram, three banks with a
// fixed one cycle read latency and held read data
//////////////////////////////////////////////////////////////////////
`default_nettype none

module sdram_store import snes_mem_pkg::*; (
    input  logic                wclk,
    input  logic                resetn,
    input  addr_t               cpu_addr,
    input  word_t               cpu_din,
    input  byte_en_t            cpu_ds,
    input  mem_port_e           cpu_port,
    input  logic                cpu_rd,
    input  logic                cpu_wr,
    input  logic [BSRAM_AW-1:0] bsram_req_addr,
    input  byte_t               bsram_req_din,
    input  logic                bsram_req_rd,
    input  logic                bsram_req_wr,
    input  logic [ARAM_AW-1:0]  aram_addr,
    input  byte_t               aram_d,
    input  logic                aram_rd,
    input  logic                aram_wr,
    output word_t               port0_q,    // rom return
    output word_t               port1_q,    // wram return
    output byte_t               bsram_dout,
    output word_t               aram_dout   // byte in both lanes
);

    word_t cpu_mem   [2**STORE_AW];
    byte_t bsram_mem [2**BSRAM_STORE_AW];
    byte_t aram_mem  [2**ARAM_STORE_AW];

    logic [STORE_AW-1:0]       cpu_idx;
    logic [BSRAM_STORE_AW-1:0] bsram_idx;
    logic [ARAM_STORE_AW-1:0]  aram_idx;

    // word index, upper address bits just wrap
    assign cpu_idx   = cpu_addr[STORE_AW:1];
    assign bsram_idx = bsram_req_addr[BSRAM_STORE_AW-1:0];
    assign aram_idx  = aram_addr[ARAM_STORE_AW-1:0];

    // writes, cpu bank is lane masked
    always_ff @(posedge wclk) begin
        if (cpu_wr) begin
            if (cpu_ds[0])
                cpu_mem[cpu_idx][7:0] <= cpu_din[7:0];
            if (cpu_ds[1])
                cpu_mem[cpu_idx][15:8] <= cpu_din[15:8];
        end
        if (bsram_req_wr)
            bsram_mem[bsram_idx] <= bsram_req_din;
        if (aram_wr)
            aram_mem[aram_idx] <= aram_d;
    end

    // reads land one edge later and hold until the next read
    always_ff @(posedge wclk) begin
        if (!resetn) begin
            port0_q    <= '0;
            port1_q    <= '0;
            bsram_dout <= '0;
            aram_dout  <= '0;
        end else begin
            if (cpu_rd) begin
                if (cpu_port == PORT_ROM)
                    port0_q <= cpu_mem[cpu_idx];
                else
                    port1_q <= cpu_mem[cpu_idx];
            end
            if (bsram_req_rd)
                bsram_dout <= bsram_mem[bsram_idx];
            if (aram_rd)
                aram_dout <= {aram_mem[aram_idx], aram_mem[aram_idx]};
        end
    end

endmodule

`default_nettype wire

// File: read_steer.sv
//////////////////////////////////////////////////////////////////////
// read steering, picks byte lanes of returned words for rom,
// wram and aram
//////////////////////////////////////////////////////////////////////
`default_nettype none

module read_steer import snes_mem_pkg::*; (
    input  logic               wclk,
    input  addr_t              rom_addr,
    input  logic               rom_word,    // 16-bit rom fetch
    input  word_t              port0_q,
    input  logic [WRAM_AW-1:0] wram_addr,
    input  word_t              port1_q,
    input  logic [ARAM_AW-1:0] aram_addr,
    input  logic               aram_rd,
    input  word_t              aram_dout,
    output word_t              rom_q,
    output byte_t              wram_q,
    output byte_t              aram_q
);

    logic aram_lsb;     // address bit 0 of the last aram read

    // odd byte reads want the high byte in the low lane
    assign rom_q = (rom_word | ~rom_addr[0]) ? port0_q
                                             : {port0_q[7:0], port0_q[15:8]};

    assign wram_q = wram_addr[0] ? port1_q[15:8] : port1_q[7:0];

    // aram data comes one edge after the read, so keep the lane
    always_ff @(posedge wclk) begin
        if (aram_rd)
            aram_lsb <= aram_addr[0];
    end

    assign aram_q = aram_lsb ? aram_dout[15:8] : aram_dout[7:0];

endmodule

`default_nettype wire

// File: sdram_request.sv
//////////////////////////////////////////////////////////////////////
// memory request builder, run enable, loader address and the
// registered cpu port and bsram requests, plus aram strobes
//////////////////////////////////////////////////////////////////////
`default_nettype none

module sdram_request import snes_mem_pkg::*; (
    input  logic                wclk,
    input  logic                resetn,
    input  logic                sysclkf_ce,     // core fall strobe
    input  logic                sysclkr_ce,     // core rise strobe
    input  logic                pause,          // frame sync hold
    input  logic                loader_fail,
    input  logic                loading,
    input  logic                loader_valid,   // one pulse per byte
    input  byte_t               loader_data,
    input  byte_t               map_ctrl,
    input  addr_t               rom_addr,
    input  logic                rom_ce_n,
    input  logic [WRAM_AW-1:0]  wram_addr,
    input  logic                wram_ce_n,
    input  logic                wram_rd_n,
    input  logic                wram_we_n,
    input  byte_t               wram_d,
    input  logic [BSRAM_AW-1:0] bsram_addr,
    input  logic                bsram_ce_n,
    input  logic                bsram_rd_n,
    input  logic                bsram_we_n,
    input  byte_t               bsram_d,
    input  logic                aram_ce_n,
    input  logic                aram_oe_n,
    input  logic                aram_we_n,
    output logic                enable,
    output addr_t               cpu_addr,
    output word_t               cpu_din,
    output byte_en_t            cpu_ds,
    output mem_port_e           cpu_port,
    output logic                cpu_rd,
    output logic                cpu_wr,
    output logic [BSRAM_AW-1:0] bsram_req_addr,
    output byte_t               bsram_req_din,
    output logic                bsram_req_rd,
    output logic                bsram_req_wr,
    output logic                aram_rd,
    output logic                aram_wr
);

    logic     f2, r2;           // strobes qualified by enable, one edge late
    logic     loading_r;        // for rising edge of loading
    addr_t    loader_addr;      // next byte address of the loader
    logic     wram_rd, wram_wr;
    logic     bsram_force_rd;
    req_src_e req_src;

    assign wram_rd = ~wram_ce_n & ~wram_rd_n;
    assign wram_wr = ~wram_ce_n & ~wram_we_n;
    assign aram_rd = ~aram_ce_n & ~aram_oe_n;  // aram is not strobe gated
    assign aram_wr = ~aram_ce_n & ~aram_we_n;
    assign bsram_force_rd = (map_ctrl[7:4] == MAP_BSRAM_FORCE_RD);

    // core runs only while nothing holds it
    always_ff @(posedge wclk) begin
        if (!resetn) begin
            enable <= 1'b0;
            f2     <= 1'b0;
            r2     <= 1'b0;
        end else begin
            enable <= ~pause & ~loader_fail;
            f2     <= sysclkf_ce & enable;
            r2     <= sysclkr_ce & enable;
        end
    end

    // loader address, restarts at 0 for every load
    always_ff @(posedge wclk) begin
        if (!resetn) begin
            loading_r   <= 1'b0;
            loader_addr <= '0;
        end else begin
            loading_r <= loading;
            if (loading & ~loading_r)
                loader_addr <= '0;
            else if (loading & loader_valid)
                loader_addr <= loader_addr + addr_t'(1);
        end
    end

    // fixed priority, loader beats rom beats wram
    always_comb begin
        if (loading & loader_valid)
            req_src = SRC_LOADER;       // not gated by enable
        else if (~rom_ce_n & f2)
            req_src = SRC_ROM;
        else if (wram_rd | wram_wr)
            req_src = SRC_WRAM;
        else
            req_src = SRC_NONE;
    end

    always_ff @(posedge wclk) begin
        if (!resetn) begin
            cpu_rd <= 1'b0;
            cpu_wr <= 1'b0;
        end else begin
            cpu_rd <= (req_src == SRC_ROM) | ((req_src == SRC_WRAM) & wram_rd & f2);
            cpu_wr <= (req_src == SRC_LOADER) | ((req_src == SRC_WRAM) & wram_wr & r2);
        end
    end

    // address, lanes and data of the winner, held otherwise
    always_ff @(posedge wclk) begin
        case (req_src)
            SRC_LOADER: begin
                cpu_addr <= loader_addr;
                cpu_din  <= {loader_data, loader_data};
                cpu_ds   <= {loader_addr[0], ~loader_addr[0]};  // odd -> high lane
                cpu_port <= PORT_ROM;
            end
            SRC_ROM: begin
                cpu_addr <= rom_addr;
                cpu_ds   <= 2'b11;      // whole word back
                cpu_port <= PORT_ROM;
            end
            SRC_WRAM: begin
                cpu_addr <= {WRAM_BASE_HI, wram_addr};
                cpu_din  <= {wram_d, wram_d};
                cpu_ds   <= {wram_addr[0], ~wram_addr[0]};
                cpu_port <= PORT_WRAM;
            end
            default: ;
        endcase
    end

    // bsram request, one edge after the core strobe
    always_ff @(posedge wclk) begin
        if (!resetn) begin
            bsram_req_rd <= 1'b0;
            bsram_req_wr <= 1'b0;
        end else begin
            bsram_req_rd <= ~bsram_ce_n & (~bsram_rd_n | bsram_force_rd) & f2;
            bsram_req_wr <= ~bsram_ce_n & ~bsram_we_n & r2;
        end
    end

    always_ff @(posedge wclk) begin
        bsram_req_addr <= bsram_addr;
        bsram_req_din  <= bsram_d;
    end

endmodule

`default_nettype wire

// File: snes_mem_pkg.sv
//////////////////////////////////////////////////////////////////////
// snes memory glue, shared widths, address map and types
// used by the request, store and read steering blocks
//////////////////////////////////////////////////////////////////////
`default_nettype none

package snes_mem_pkg;

    // bus widths
    localparam int ADDR_W   = 24;   // cpu side byte address
    localparam int WRAM_AW  = 17;   // 128KB work ram
    localparam int BSRAM_AW = 20;   // battery ram, up to 1MB
    localparam int ARAM_AW  = 16;   // 64KB audio ram

    // wram lives in banks EE,EF of the shared space
    localparam logic [6:0] WRAM_BASE_HI = 7'b1110_111;

    // mapper upper nibble where bsram reads skip rd_n
    localparam logic [3:0] MAP_BSRAM_FORCE_RD = 4'hC;

    // on-chip store sizes
    localparam int STORE_AW       = 12; // word index, addr bits 12:1
    localparam int BSRAM_STORE_AW = 11; // byte index
    localparam int ARAM_STORE_AW  = 11; // byte index

    typedef logic [7:0]        byte_t;
    typedef logic [15:0]       word_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [1:0]        byte_en_t;   // [1] high byte, [0] low byte

    // read return port of the cpu side
    typedef enum logic {
        PORT_ROM,       // port0
        PORT_WRAM       // port1
    } mem_port_e;

    // winner of the cpu port arbitration
    typedef enum logic [1:0] {
        SRC_NONE,
        SRC_LOADER,
        SRC_ROM,
        SRC_WRAM
    } req_src_e;

endpackage

`default_nettype wire
